/* rtl/core_macros.svh */
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// instruction queue entries
// the source starts out with this many credits
`define QUEUE_DEPTH 4

// words in the back-end data memory, power of two
`define DMEM_WORDS 16

// issue slots per cycle
// dispatch and the back end are written for two
`define ISSUE_W 2

`endif

/* rtl/isa_pkg.sv */
package isa_pkg;

    // operation codes of the supported subset
    typedef enum logic [7:0] {
        ALU_NOP       = 8'h00,
        ALU_ADD       = 8'h01,
        ALU_SUB       = 8'h02,
        ALU_AND       = 8'h03,
        ALU_OR        = 8'h04,
        ALU_XOR       = 8'h05,
        ALU_ADDI      = 8'h06,
        ALU_LU12I     = 8'h07,     // imm arrives already shifted
        ALU_PCADDU12I = 8'h08,
        ALU_LDW       = 8'h10,
        ALU_STW       = 8'h11
    } alu_op_e;

    // selector class, drives the pairing rule
    typedef enum logic [2:0] {
        SEL_ALU        = 3'b001,
        SEL_LOAD_STORE = 3'b011
    } op_class_e;

    function automatic logic is_load(alu_op_e op);
        return op == ALU_LDW;
    endfunction

endpackage

/* rtl/pipe_pkg.sv */
package pipe_pkg;

    import isa_pkg::*;

    // one pre-decoded instruction
    typedef struct packed {
        logic [31:0]     pc;
        alu_op_e         alu_op;
        op_class_e       op_class;
        logic [1:0]      rd_en;       // source read enables
        logic [1:0][4:0] rs_addr;
        logic            wr_en;
        logic [4:0]      wr_addr;
        logic [31:0]     imm;
    } dec_inst_t;

    // issue slot handed to execute with resolved operands
    typedef struct packed {
        logic             valid;
        dec_inst_t        inst;
        logic [1:0][31:0] operand;
    } issue_slot_t;

    // one forwarded result
    typedef struct packed {
        logic        en;
        logic [4:0]  addr;
        logic [31:0] data;
    } bypass_t;

endpackage

/* rtl/issue_if.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

interface issue_if import pipe_pkg::*; ();

    issue_slot_t         slot [`ISSUE_W];
    logic [`ISSUE_W-1:0] valid;

    // valid bits mirrored out of the slots
    for (genvar i = 0; i < `ISSUE_W; i++) begin : g_valid
        assign valid[i] = slot[i].valid;
    end

    modport issuer (
        output slot,
        input  valid
    );

    modport executor (
        input slot,
        input valid
    );

endinterface

/* rtl/regfile.sv */
`timescale 1ns/1ps

module regfile (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic [4:0]  raddr_i [4],
    output logic [31:0] rdata_o [4],
    input  logic [1:0]  we_i,
    input  logic [4:0]  waddr_i [2],
    input  logic [31:0] wdata_i [2]
);

    logic [31:0] regs [32];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int r = 0; r < 32; r++) begin
                regs[r] <= '0;
            end
        end else begin
            // port 1 is written last and wins on a collision
            for (int w = 0; w < 2; w++) begin
                if (we_i[w] && waddr_i[w] != 5'd0) begin
                    regs[waddr_i[w]] <= wdata_i[w];
                end
            end
        end
    end

    for (genvar k = 0; k < 4; k++) begin : g_rd
        assign rdata_o[k] = regs[raddr_i[k]];    // r0 is never written

        r0_reads_zero: assert property (@(posedge clk) disable iff (!rst_n_i)
            raddr_i[k] == 5'd0 |-> rdata_o[k] == 32'd0);
    end

endmodule

/* rtl/inst_queue.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module inst_queue import pipe_pkg::*; (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                flush_i,
    input  logic [`ISSUE_W-1:0] push_valid_i,
    input  dec_inst_t           push_inst_i [`ISSUE_W],
    output logic [`ISSUE_W-1:0] head_valid_o,
    output dec_inst_t           head_inst_o [`ISSUE_W],
    input  logic [1:0]          pop_cnt_i,
    output logic [2:0]          credit_o
);

    localparam int DEPTH = `QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);      // pointers wrap, depth is a power of two
    localparam int CNT_W = $clog2(DEPTH + 1);

    dec_inst_t        mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] push_cnt;
    logic [CNT_W-1:0] pop_cnt;

    assign push_cnt = CNT_W'(push_valid_i[0]) + CNT_W'(push_valid_i[1]);
    assign pop_cnt  = CNT_W'(pop_cnt_i);

    // a flush frees every entry, including this cycle's pushes
    assign credit_o = flush_i ? 3'(count + push_cnt) : 3'(pop_cnt);

    for (genvar i = 0; i < `ISSUE_W; i++) begin : g_head
        assign head_valid_o[i] = count > CNT_W'(i);
        assign head_inst_o[i]  = mem[rd_ptr + PTR_W'(i)];
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (flush_i) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            rd_ptr <= rd_ptr + PTR_W'(pop_cnt);
            wr_ptr <= wr_ptr + PTR_W'(push_cnt);
            count  <= count + push_cnt - pop_cnt;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `ISSUE_W; i++) begin
            if (push_valid_i[i]) begin
                mem[wr_ptr + PTR_W'(i)] <= push_inst_i[i];
            end
        end
    end

    no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n_i)
        (count + push_cnt) <= ((CNT_W + 1)'(DEPTH) + pop_cnt));

    pop_within_count: assert property (@(posedge clk) disable iff (!rst_n_i)
        pop_cnt <= count);

endmodule

/* rtl/operand_bypass.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module operand_bypass import isa_pkg::*, pipe_pkg::*; (
    input  dec_inst_t   head_inst_i [`ISSUE_W],
    input  logic [31:0] rf_data_i [2*`ISSUE_W],
    input  bypass_t     ex_byp_i [`ISSUE_W],
    input  bypass_t     mem_byp_i [`ISSUE_W],
    input  bypass_t     wb_byp_i [`ISSUE_W],
    output logic [31:0] operand_o [2*`ISSUE_W]
);

    function automatic logic hit(bypass_t byp, logic [4:0] addr);
        return byp.en && byp.addr == addr;
    endfunction

    // operand k is source k%2 of head k/2
    for (genvar k = 0; k < 2 * `ISSUE_W; k++) begin : g_opnd
        localparam int SLOT = k / 2;
        localparam int SRC  = k % 2;

        logic [4:0] addr;

        assign addr = head_inst_i[SLOT].rs_addr[SRC];

        // lowest priority first, each later match overrides
        always_comb begin
            operand_o[k] = rf_data_i[k];
            for (int j = 0; j < `ISSUE_W; j++) begin
                if (hit(wb_byp_i[j], addr)) operand_o[k] = wb_byp_i[j].data;
            end
            for (int j = 0; j < `ISSUE_W; j++) begin
                if (hit(mem_byp_i[j], addr)) operand_o[k] = mem_byp_i[j].data;
            end
            for (int j = 0; j < `ISSUE_W; j++) begin
                if (hit(ex_byp_i[j], addr)) operand_o[k] = ex_byp_i[j].data;
            end
            if (head_inst_i[SLOT].alu_op == ALU_PCADDU12I) begin
                operand_o[k] = head_inst_i[SLOT].pc;
            end
            if (addr == 5'd0) begin
                operand_o[k] = '0;
            end
            if (!head_inst_i[SLOT].rd_en[SRC]) begin
                operand_o[k] = head_inst_i[SLOT].imm;    // unused source carries imm
            end
        end
    end

endmodule

/* rtl/dispatch.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module dispatch import isa_pkg::*, pipe_pkg::*; (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                pause_i,
    input  logic                flush_i,
    input  logic [`ISSUE_W-1:0] head_valid_i,
    input  dec_inst_t           head_inst_i [`ISSUE_W],
    input  logic [31:0]         operand_i [2*`ISSUE_W],
    input  logic [`ISSUE_W-1:0] ex_load_i,
    input  bypass_t             ex_byp_i [`ISSUE_W],
    output logic [4:0]          rf_raddr_o [2*`ISSUE_W],
    output logic [1:0]          pop_cnt_o,
    issue_if.issuer             issue
);

    logic                raw_pair;
    logic                ls_pair;
    logic                pair_ok;
    logic                load_use;
    logic                advance;
    logic [`ISSUE_W-1:0] issue_en;
    logic [`ISSUE_W-1:0] use_hit;
    logic [`ISSUE_W-1:0] valid_q;
    issue_slot_t         slot_d [`ISSUE_W];
    issue_slot_t         slot_q [`ISSUE_W];

    // true if inst reads a nonzero register addr
    function automatic logic reads_reg(dec_inst_t inst, logic [4:0] addr);
        return addr != 5'd0
            && ((inst.rd_en[0] && inst.rs_addr[0] == addr)
             || (inst.rd_en[1] && inst.rs_addr[1] == addr));
    endfunction

    for (genvar k = 0; k < 2 * `ISSUE_W; k++) begin : g_raddr
        assign rf_raddr_o[k] = head_inst_i[k / 2].rs_addr[k % 2];
    end

    assign raw_pair = head_inst_i[0].wr_en && reads_reg(head_inst_i[1], head_inst_i[0].wr_addr);
    assign ls_pair  = head_inst_i[0].op_class == SEL_LOAD_STORE
                   || head_inst_i[1].op_class == SEL_LOAD_STORE;
    assign pair_ok  = &head_valid_i && !ls_pair && !raw_pair;
    assign issue_en = {pair_ok, head_valid_i[0]};

    // load in ex feeding any head that would issue
    always_comb begin
        for (int h = 0; h < `ISSUE_W; h++) begin
            use_hit[h] = 1'b0;
            for (int j = 0; j < `ISSUE_W; j++) begin
                if (issue_en[h] && ex_load_i[j] && reads_reg(head_inst_i[h], ex_byp_i[j].addr)) begin
                    use_hit[h] = 1'b1;
                end
            end
        end
    end

    assign load_use  = |use_hit;
    assign advance   = !pause_i && !flush_i && !load_use;
    assign pop_cnt_o = advance ? 2'(issue_en[0]) + 2'(issue_en[1]) : 2'd0;

    always_comb begin
        for (int i = 0; i < `ISSUE_W; i++) begin
            slot_d[i].valid      = issue_en[i];
            slot_d[i].inst       = head_inst_i[i];
            slot_d[i].operand[0] = operand_i[2 * i];
            slot_d[i].operand[1] = operand_i[2 * i + 1];
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= advance ? issue_en : '0;    // bubble on stall, pause, flush
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            slot_q <= slot_d;    // payload held otherwise
        end
    end

    for (genvar i = 0; i < `ISSUE_W; i++) begin : g_out
        assign issue.slot[i] = '{valid: valid_q[i], inst: slot_q[i].inst,
                                 operand: slot_q[i].operand};
    end

    slot1_needs_slot0: assert property (@(posedge clk) disable iff (!rst_n_i)
        issue.valid[1] |-> issue.valid[0]);

endmodule

/* rtl/backend.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module backend import isa_pkg::*, pipe_pkg::*; (
    input  logic                clk,
    input  logic                rst_n_i,
    issue_if.executor           issue,
    output bypass_t             ex_byp_o [`ISSUE_W],
    output bypass_t             mem_byp_o [`ISSUE_W],
    output bypass_t             wb_byp_o [`ISSUE_W],
    output logic [`ISSUE_W-1:0] ex_load_o,
    output logic [`ISSUE_W-1:0] wb_en_o,
    output logic [4:0]          wb_addr_o [`ISSUE_W],
    output logic [31:0]         wb_data_o [`ISSUE_W]
);

    localparam int IDX_W = $clog2(`DMEM_WORDS);

    logic [31:0]         ex_res [`ISSUE_W];
    logic [`ISSUE_W-1:0] mem_valid;
    dec_inst_t           mem_inst [`ISSUE_W];
    logic [31:0]         mem_res [`ISSUE_W];
    logic [31:0]         mem_sdata [`ISSUE_W];
    logic [IDX_W-1:0]    mem_idx [`ISSUE_W];
    logic [31:0]         mem_data [`ISSUE_W];
    logic [31:0]         dmem [`DMEM_WORDS];

    function automatic logic [31:0] alu(issue_slot_t s);
        logic [31:0] a;
        logic [31:0] b;
        a = s.operand[0];
        b = s.operand[1];
        case (s.inst.alu_op)
            ALU_ADD, ALU_ADDI, ALU_PCADDU12I: return a + b;    // pc already in a
            ALU_SUB:                          return a - b;
            ALU_AND:                          return a & b;
            ALU_OR:                           return a | b;
            ALU_XOR:                          return a ^ b;
            ALU_LU12I:                        return s.inst.imm;
            ALU_LDW, ALU_STW:                 return a + s.inst.imm;   // byte address
            default:                          return '0;
        endcase
    endfunction

    always_comb begin
        for (int i = 0; i < `ISSUE_W; i++) begin
            ex_res[i]    = alu(issue.slot[i]);
            ex_load_o[i] = issue.valid[i] && issue.slot[i].inst.wr_en
                        && is_load(issue.slot[i].inst.alu_op);
            // load data not ready yet
            ex_byp_o[i]  = '{en: issue.valid[i] && issue.slot[i].inst.wr_en
                                 && !is_load(issue.slot[i].inst.alu_op),
                             addr: issue.slot[i].inst.wr_addr,
                             data: ex_res[i]};
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mem_valid <= '0;
        end else begin
            mem_valid <= issue.valid;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `ISSUE_W; i++) begin
            mem_inst[i]  <= issue.slot[i].inst;
            mem_res[i]   <= ex_res[i];
            mem_sdata[i] <= issue.slot[i].operand[1];    // store data from rs2
        end
    end

    always_comb begin
        for (int i = 0; i < `ISSUE_W; i++) begin
            mem_idx[i]   = mem_res[i][IDX_W+1:2];    // word index wraps
            mem_data[i]  = is_load(mem_inst[i].alu_op) ? dmem[mem_idx[i]] : mem_res[i];
            mem_byp_o[i] = '{en: mem_valid[i] && mem_inst[i].wr_en,
                             addr: mem_inst[i].wr_addr,
                             data: mem_data[i]};
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `ISSUE_W; i++) begin
            if (mem_valid[i] && mem_inst[i].alu_op == ALU_STW) begin
                dmem[mem_idx[i]] <= mem_sdata[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_en_o <= '0;
        end else begin
            for (int i = 0; i < `ISSUE_W; i++) begin
                wb_en_o[i] <= mem_valid[i] && mem_inst[i].wr_en;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `ISSUE_W; i++) begin
            wb_addr_o[i] <= mem_inst[i].wr_addr;
            wb_data_o[i] <= mem_data[i];
        end
    end

    for (genvar i = 0; i < `ISSUE_W; i++) begin : g_wb_byp
        assign wb_byp_o[i] = '{en: wb_en_o[i], addr: wb_addr_o[i], data: wb_data_o[i]};
    end

    // loads and stores only ever travel alone in slot 0
    mem_op_in_slot0: assert property (@(posedge clk) disable iff (!rst_n_i)
        issue.valid[1] |-> issue.slot[1].inst.op_class != SEL_LOAD_STORE);

endmodule

/* rtl/issue_top.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module issue_top import pipe_pkg::*; (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                pause_i,
    input  logic                flush_i,
    input  logic [`ISSUE_W-1:0] push_valid_i,
    input  dec_inst_t           push_inst_i [`ISSUE_W],
    output logic [2:0]          credit_o,
    output logic [`ISSUE_W-1:0] wb_en_o,
    output logic [4:0]          wb_addr_o [`ISSUE_W],
    output logic [31:0]         wb_data_o [`ISSUE_W]
);

    logic [`ISSUE_W-1:0] head_valid;
    dec_inst_t           head_inst [`ISSUE_W];
    logic [1:0]          pop_cnt;
    logic [4:0]          rf_raddr [2*`ISSUE_W];
    logic [31:0]         rf_rdata [2*`ISSUE_W];
    logic [31:0]         operand [2*`ISSUE_W];
    bypass_t             ex_byp [`ISSUE_W];
    bypass_t             mem_byp [`ISSUE_W];
    bypass_t             wb_byp [`ISSUE_W];
    logic [`ISSUE_W-1:0] ex_load;

    issue_if u_issue_if ();

    inst_queue u_inst_queue (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .push_valid_i (push_valid_i),
        .push_inst_i  (push_inst_i),
        .head_valid_o (head_valid),
        .head_inst_o  (head_inst),
        .pop_cnt_i    (pop_cnt),
        .credit_o     (credit_o)
    );

    regfile u_regfile (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .raddr_i (rf_raddr),
        .rdata_o (rf_rdata),
        .we_i    (wb_en_o),      // writeback ports
        .waddr_i (wb_addr_o),
        .wdata_i (wb_data_o)
    );

    operand_bypass u_operand_bypass (
        .head_inst_i (head_inst),
        .rf_data_i   (rf_rdata),
        .ex_byp_i    (ex_byp),
        .mem_byp_i   (mem_byp),
        .wb_byp_i    (wb_byp),
        .operand_o   (operand)
    );

    dispatch u_dispatch (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .pause_i      (pause_i),
        .flush_i      (flush_i),
        .head_valid_i (head_valid),
        .head_inst_i  (head_inst),
        .operand_i    (operand),
        .ex_load_i    (ex_load),
        .ex_byp_i     (ex_byp),
        .rf_raddr_o   (rf_raddr),
        .pop_cnt_o    (pop_cnt),
        .issue        (u_issue_if.issuer)
    );

    backend u_backend (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .issue     (u_issue_if.executor),
        .ex_byp_o  (ex_byp),
        .mem_byp_o (mem_byp),
        .wb_byp_o  (wb_byp),
        .ex_load_o (ex_load),
        .wb_en_o   (wb_en_o),
        .wb_addr_o (wb_addr_o),
        .wb_data_o (wb_data_o)
    );

endmodule

/* tb/tb_issue_top.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module tb_issue_top import isa_pkg::*, pipe_pkg::*; ();

    localparam logic [31:0] PC_BASE = 32'h0000_1000;
    localparam int N_MAIN  = 22;
    localparam int N_PAUSE = 4;
    localparam int N_FLUSH = 4;
    localparam int IDX_W   = $clog2(`DMEM_WORDS);

    logic                clk;
    logic                rst_n_i;
    logic                pause_i;
    logic                flush_i;
    logic [`ISSUE_W-1:0] push_valid_i;
    dec_inst_t           push_inst_i [`ISSUE_W];
    logic [2:0]          credit_o;
    logic [`ISSUE_W-1:0] wb_en_o;
    logic [4:0]          wb_addr_o [`ISSUE_W];
    logic [31:0]         wb_data_o [`ISSUE_W];

    dec_inst_t   prog [$];        // stimulus table in program order
    logic [4:0]  exp_addr [$];    // expected writeback stream
    logic [31:0] exp_data [$];
    logic [31:0] lcg_state;
    int          main_writes;
    int          pushed;
    bit          aborted;
    int          checked = 0;     // writebacks seen by the monitor
    int          returned = 0;    // sum of credit_o
    int          flush_credit = -1;
    int          mon_errors = 0;
    int          crd_errors = 0;
    int          chk_errors = 0;

    issue_top dut0 (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .pause_i      (pause_i),
        .flush_i      (flush_i),
        .push_valid_i (push_valid_i),
        .push_inst_i  (push_inst_i),
        .credit_o     (credit_o),
        .wb_en_o      (wb_en_o),
        .wb_addr_o    (wb_addr_o),
        .wb_data_o    (wb_data_o)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_next(logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic add_inst(input alu_op_e op, input logic [4:0] rd, input logic [4:0] rs0,
                            input logic [4:0] rs1, input logic [31:0] imm);
        dec_inst_t inst;
        inst            = '0;
        inst.pc         = PC_BASE + 32'(4 * prog.size());
        inst.alu_op     = op;
        inst.op_class   = (op == ALU_LDW || op == ALU_STW) ? SEL_LOAD_STORE : SEL_ALU;
        inst.wr_en      = (op != ALU_STW);
        inst.wr_addr    = rd;
        inst.rs_addr[0] = rs0;
        inst.rs_addr[1] = rs1;
        inst.imm        = imm;
        case (op)
            ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_STW: inst.rd_en = 2'b11;
            ALU_ADDI, ALU_LDW, ALU_PCADDU12I:                    inst.rd_en = 2'b01;
            default:                                             inst.rd_en = 2'b00;
        endcase
        prog.push_back(inst);
    endtask

    task automatic load_program();
        add_inst(ALU_LU12I,     5'd1,  5'd0,  5'd0,  32'h1234_5000);
        add_inst(ALU_ADDI,      5'd2,  5'd0,  5'd0,  32'h0000_00AB);
        add_inst(ALU_PCADDU12I, 5'd3,  5'd31, 5'd0,  32'h0000_2000);   // pc enters on source 0
        add_inst(ALU_ADDI,      5'd4,  5'd0,  5'd0,  32'hFFFF_FFFB);
        add_inst(ALU_ADD,       5'd5,  5'd1,  5'd2,  32'h0);
        add_inst(ALU_SUB,       5'd6,  5'd5,  5'd4,  32'h0);           // RAW inside a pair
        add_inst(ALU_XOR,       5'd7,  5'd6,  5'd3,  32'h0);
        add_inst(ALU_AND,       5'd8,  5'd7,  5'd1,  32'h0);
        add_inst(ALU_OR,        5'd9,  5'd8,  5'd0,  32'h0);
        add_inst(ALU_ADDI,      5'd10, 5'd9,  5'd0,  32'h0000_0010);
        add_inst(ALU_STW,       5'd0,  5'd0,  5'd5,  32'h0000_0008);
        add_inst(ALU_LDW,       5'd11, 5'd0,  5'd0,  32'h0000_0008);
        add_inst(ALU_ADD,       5'd12, 5'd11, 5'd11, 32'h0);           // load-use stall
        add_inst(ALU_STW,       5'd0,  5'd4,  5'd12, 32'h0000_0019);
        add_inst(ALU_LDW,       5'd13, 5'd4,  5'd0,  32'h0000_0019);
        add_inst(ALU_SUB,       5'd14, 5'd13, 5'd1,  32'h0);
        add_inst(ALU_ADD,       5'd1,  5'd14, 5'd5,  32'h0);
        add_inst(ALU_LU12I,     5'd15, 5'd0,  5'd0,  32'hABCD_E000);
        add_inst(ALU_XOR,       5'd16, 5'd1,  5'd15, 32'h0);
        add_inst(ALU_ADDI,      5'd16, 5'd16, 5'd0,  32'h0000_0001);
        add_inst(ALU_LDW,       5'd17, 5'd0,  5'd0,  32'h0000_0008);
        add_inst(ALU_OR,        5'd18, 5'd17, 5'd16, 32'h0);
        // held in the queue by pause
        add_inst(ALU_ADD,       5'd19, 5'd18, 5'd1,  32'h0);
        add_inst(ALU_ADDI,      5'd20, 5'd19, 5'd0,  32'h0000_0007);
        add_inst(ALU_PCADDU12I, 5'd21, 5'd31, 5'd0,  32'h0000_5000);
        add_inst(ALU_SUB,       5'd22, 5'd20, 5'd21, 32'h0);
        // flushed before issue
        add_inst(ALU_ADDI,      5'd23, 5'd0,  5'd0,  32'h0000_0001);
        add_inst(ALU_ADDI,      5'd24, 5'd0,  5'd0,  32'h0000_0002);
        add_inst(ALU_ADDI,      5'd25, 5'd0,  5'd0,  32'h0000_0003);
        add_inst(ALU_ADDI,      5'd26, 5'd0,  5'd0,  32'h0000_0004);
    endtask

    // in-order model of the first n table entries
    task automatic build_expected(input int n);
        logic [31:0]      regs [32];
        logic [31:0]      dmem [`DMEM_WORDS];
        logic [31:0]      a;
        logic [31:0]      b;
        logic [31:0]      res;
        logic [IDX_W-1:0] idx;
        dec_inst_t        inst;
        for (int r = 0; r < 32; r++) regs[r] = '0;
        for (int m = 0; m < `DMEM_WORDS; m++) dmem[m] = '0;
        for (int i = 0; i < n; i++) begin
            inst = prog[i];
            a    = regs[inst.rs_addr[0]];
            b    = regs[inst.rs_addr[1]];
            idx  = IDX_W'(((a + inst.imm) >> 2) % `DMEM_WORDS);
            res  = '0;
            case (inst.alu_op)
                ALU_ADD:       res = a + b;
                ALU_SUB:       res = a - b;
                ALU_AND:       res = a & b;
                ALU_OR:        res = a | b;
                ALU_XOR:       res = a ^ b;
                ALU_ADDI:      res = a + inst.imm;
                ALU_LU12I:     res = inst.imm;
                ALU_PCADDU12I: res = inst.pc + inst.imm;
                ALU_LDW:       res = dmem[idx];
                ALU_STW:       dmem[idx] = b;
                default:       res = '0;
            endcase
            if (inst.wr_en) begin
                if (inst.wr_addr != 5'd0) regs[inst.wr_addr] = res;
                exp_addr.push_back(inst.wr_addr);
                exp_data.push_back(res);
            end
        end
    endtask

    // pushes table entries [first, last) within the credits held
    task automatic push_range(input int first, input int last);
        int idx;
        int n;
        int avail;
        int idle;
        idx  = first;
        idle = 0;
        while (idx < last && !aborted) begin
            @(negedge clk);
            push_valid_i = '0;
            lcg_state    = lcg_next(lcg_state);
            n            = lcg_state[16] ? 2 : 1;
            avail        = `QUEUE_DEPTH + returned - pushed;
            if (n > last - idx) n = last - idx;
            if (n > avail) n = avail;
            for (int k = 0; k < n; k++) begin
                push_valid_i[k] = 1'b1;
                push_inst_i[k]  = prog[idx + k];
            end
            idx    += n;
            pushed += n;
            idle    = (n == 0) ? idle + 1 : 0;
            if (idle > 100) begin
                chk_errors++;
                aborted = 1'b1;
                $display("timeout at %0t waiting for credits, %0d instructions left",
                         $time, last - idx);
            end
        end
        @(negedge clk);
        push_valid_i = '0;
    endtask

    task automatic wait_writebacks(input int target);
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (checked < target && !aborted) begin
            @(posedge clk);
            cycles++;
            if (cycles > 400) begin
                chk_errors++;
                aborted = 1'b1;
                $display("timeout at %0t waiting for writebacks, %0d of %0d seen",
                         $time, checked, target);
            end
        end
    endtask

    task automatic check_no_writeback(input int cycles, input string what);
        int start;
        @(posedge clk);
        start = checked;
        repeat (cycles) @(posedge clk);
        if (checked != start) begin
            chk_errors++;
            $display("%0d writebacks happened %s", checked - start, what);
        end
    endtask

    // writeback monitor, slot 0 is older
    always @(negedge clk) begin
        if (rst_n_i) begin
            for (int s = 0; s < `ISSUE_W; s++) begin
                if (wb_en_o[s]) begin
                    if (checked >= exp_addr.size()) begin
                        mon_errors++;
                        $display("unexpected writeback at %0t on slot %0d to r%0d",
                                 $time, s, wb_addr_o[s]);
                    end else begin
                        if (wb_addr_o[s] != exp_addr[checked]) begin
                            mon_errors++;
                            $display("FAIL t=%0t wb_addr_o[%0d] got %0d expected %0d",
                                     $time, s, wb_addr_o[s], exp_addr[checked]);
                        end
                        if (wb_data_o[s] != exp_data[checked]) begin
                            mon_errors++;
                            $display("FAIL t=%0t wb_data_o[%0d] got %h expected %h",
                                     $time, s, wb_data_o[s], exp_data[checked]);
                        end
                    end
                    checked++;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n_i) begin
            returned = returned + int'(credit_o);
            if (flush_i) flush_credit = int'(credit_o);
            if (returned > pushed) begin
                crd_errors++;
                $display("credit_o returned %0d credits for %0d pushed instructions at %0t",
                         returned, pushed, $time);
            end
        end
    end

    initial begin
        clk          = 1'b0;
        rst_n_i      = 1'b0;
        pause_i      = 1'b0;
        flush_i      = 1'b0;
        push_valid_i = '0;
        for (int k = 0; k < `ISSUE_W; k++) push_inst_i[k] = '0;
        lcg_state   = 32'd8;
        pushed      = 0;
        aborted     = 1'b0;
        main_writes = 0;
        load_program();
        build_expected(N_MAIN + N_PAUSE);
        for (int i = 0; i < N_MAIN; i++) begin
            if (prog[i].wr_en) main_writes++;
        end

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        if (credit_o != 3'd0) begin
            chk_errors++;
            $display("FAIL t=%0t credit_o got %0d expected 0", $time, credit_o);
        end
        if (wb_en_o != '0) begin
            chk_errors++;
            $display("FAIL t=%0t wb_en_o got %b expected 0", $time, wb_en_o);
        end

        // pairs, bypass chains, stores and loads
        push_range(0, N_MAIN);
        wait_writebacks(main_writes);

        // back end drained, queue held by pause
        @(negedge clk);
        pause_i = 1'b1;
        push_range(N_MAIN, N_MAIN + N_PAUSE);
        check_no_writeback(10, "while paused");
        @(negedge clk);
        pause_i = 1'b0;
        wait_writebacks(exp_addr.size());

        // fill under pause then flush
        @(negedge clk);
        pause_i = 1'b1;
        push_range(N_MAIN + N_PAUSE, N_MAIN + N_PAUSE + N_FLUSH);
        flush_i = 1'b1;
        @(negedge clk);
        flush_i = 1'b0;
        pause_i = 1'b0;
        if (flush_credit != N_FLUSH) begin
            chk_errors++;
            $display("FAIL t=%0t credit_o got %0d expected %0d", $time, flush_credit, N_FLUSH);
        end
        check_no_writeback(12, "after the flush");

        @(negedge clk);
        if (returned != pushed) begin
            chk_errors++;
            $display("credits returned %0d but %0d instructions were pushed", returned, pushed);
        end
        if (checked != exp_addr.size()) begin
            chk_errors++;
            $display("only %0d of %0d writebacks seen", checked, exp_addr.size());
        end
        $display("errors: monitor %0d, credit %0d, other %0d; writebacks checked %0d",
                 mon_errors, crd_errors, chk_errors, checked);
        if (mon_errors + crd_errors + chk_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+rtl
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/issue_if.sv
rtl/regfile.sv
rtl/inst_queue.sv
rtl/operand_bypass.sv
rtl/dispatch.sv
rtl/backend.sv
rtl/issue_top.sv
tb/tb_issue_top.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sim.f --top-module tb_issue_top -o tb_issue_top

status=0
./obj_dir/tb_issue_top > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Simulation failed" sim.log; then
    echo "run.sh: simulation FAILED"
    exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
    echo "run.sh: simulation did not finish"
    exit 1
fi
echo "run.sh: simulation passed"
